// File: project.f
hw/led_regs_pkg.sv
hw/led_out_pkg.sv
hw/led_regfile.sv
hw/activity_stretch.sv
hw/led_output_stage.sv
hw/led_ctrl_top.sv
bench/led_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LED controller testbench with Verilator and run it.
# The run passes only if the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module led_ctrl_tb -o led_ctrl_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/led_ctrl_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "All checks passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: bench/led_ctrl_tb.sv
// ==================================================
// Testbench for the LED controller top level
// Clock, reset, bus tasks, xorshift data,
// checks by assertion and the closing report
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module led_ctrl_tb;

    import led_regs_pkg::*;
    import led_out_pkg::*;

    // Run limit sized from the activity holds and PWM windows
    localparam int CYCLE_LIMIT = 40000;
    localparam int HOLD = int'(ACTIVITY_HOLD);

    logic         clk;
    logic         rst_n;
    led_bus_req_t io;
    logic [7:0]   io_readdata;
    logic         disk_activity;
    mister_leds_t leds;
    logic [15:0]  led_register;

    int           errors;
    int           checks;
    int           cycles;
    logic [31:0]  rng_state;
    // Expected register contents
    logic [15:0]  led_model;
    ctrl_word_u   ctrl_model;
    logic [7:0]   pwm_model;

    led_ctrl_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .io            (io),
        .io_readdata   (io_readdata),
        .disk_activity (disk_activity),
        .leds          (leds),
        .led_register  (led_register)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles with %0d errors", CYCLE_LIMIT, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // Unmapped addresses never return data
    unmapped_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (io.addr > ADDR_STATUS) |-> (io_readdata == 8'h00))
    else begin
        $display("[FAIL] %0t: unmapped address %h read %h", $time, io.addr, io_readdata);
        errors++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (actual == expected) else begin
            $display("[FAIL] %0t: %s got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // One write cycle with the strobe high for a single edge
    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        io.addr  <= addr;
        io.write <= 1'b1;
        io.wdata <= data;
        @(posedge clk);
        io.write <= 1'b0;
        io.wdata <= 8'h00;
    endtask

    // Readback is combinational and sampled mid-cycle
    task automatic bus_read_check(input logic [7:0] addr, input logic [7:0] expected,
                                  input string what);
        @(posedge clk);
        io.addr  <= addr;
        io.write <= 1'b0;
        @(negedge clk);
        check_equal(io_readdata, expected, what);
    endtask

    task automatic read_all_regs;
        bus_read_check(ADDR_LED_LO, led_model[7:0], "LED low byte");
        bus_read_check(ADDR_LED_HI, led_model[15:8], "LED high byte");
        bus_read_check(ADDR_CTRL, ctrl_model.raw, "control byte");
        bus_read_check(ADDR_PWM, pwm_model, "PWM level");
    endtask

    // Activity seen high at exactly one edge
    task automatic pulse_activity;
        @(posedge clk);
        disk_activity <= 1'b1;
        @(posedge clk);
        disk_activity <= 1'b0;
    endtask

    // Disk lamp and status bit 1 over a run of cycles with the status address selected
    task automatic watch_busy(input int edges, input logic busy);
        repeat (edges) begin
            @(negedge clk);
            check_equal(leds.disk[0], busy, "disk state");
            check_equal(io_readdata, {6'b0, busy, 1'b0}, "status byte");
        end
    endtask

    // Lit cycles of gated outputs over one full PWM period
    task automatic count_duty(input logic [7:0] level);
        int lit_user;
        int lit_reg;
        lit_user = 0;
        lit_reg  = 0;
        bus_write(ADDR_PWM, level);
        repeat (256) begin
            @(negedge clk);
            lit_user += int'(leds.user);
            lit_reg  += int'(led_register[0]);
            check_equal({leds.power[1], leds.disk[1]}, 2'b11, "mode bits during PWM");
        end
        check_equal(lit_user, level, "user lamp lit cycles");
        check_equal(lit_reg, level, "LED register bit 0 lit cycles");
    endtask

    initial begin
        logic [7:0] data;
        logic [7:0] addr;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        rng_state     = 32'h6cf0;
        rst_n         = 1'b0;
        io            = '0;
        disk_activity = 1'b0;
        led_model     = 16'h0000;
        ctrl_model    = '0;
        pwm_model     = 8'hFF;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values on every address
        @(negedge clk);
        check_equal(leds, 5'b0, "lamps after reset");
        check_equal(led_register, 16'h0000, "LED register after reset");
        for (int a = 0; a < 256; a++) begin
            bus_read_check(a[7:0], (a == 3) ? 8'hFF : 8'h00, "reset readback");
        end

        // Random data to each register with PWM kept off
        for (int i = 0; i < 12; i++) begin
            random_byte(data);
            addr = i[7:0] & 8'h03;
            if (addr == ADDR_CTRL) begin
                data[5] = 1'b0;
            end
            bus_write(addr, data);
            case (addr)
                ADDR_LED_LO: led_model[7:0] = data;
                ADDR_LED_HI: led_model[15:8] = data;
                ADDR_CTRL:   ctrl_model.raw = data;
                default:     pwm_model = data;
            endcase
            @(negedge clk);
            check_equal(led_register, led_model, "LED register after write");
            read_all_regs();
        end
        // Status and unmapped writes are dropped
        bus_write(ADDR_STATUS, 8'hFF);
        bus_write(8'h05, 8'h5A);
        bus_write(8'hFF, 8'hA5);
        read_all_regs();
        bus_read_check(8'h05, 8'h00, "unmapped read");
        bus_read_check(8'hFF, 8'h00, "unmapped read");

        // Field decode of the control byte in both disk modes
        for (int i = 0; i < 8; i++) begin
            random_byte(data);
            ctrl_model.raw = data & 8'hDF;
            ctrl_model.fields.disk_mode = (i % 2 == 0);
            ctrl_model.fields.disk_on = i[1];
            bus_write(ADDR_CTRL, ctrl_model.raw);
            @(negedge clk);
            check_equal(leds.user, ctrl_model.fields.user_on, "user lamp");
            check_equal(leds.power, {ctrl_model.fields.power_mode,
                        ctrl_model.fields.power_on}, "power lamp");
            check_equal(leds.disk, {ctrl_model.fields.disk_mode,
                        ctrl_model.fields.disk_mode & ctrl_model.fields.disk_on}, "disk lamp");
            bus_read_check(ADDR_STATUS, {7'b0, ctrl_model.fields.user_on}, "status user bit");
        end

        // System mode with only power on
        ctrl_model.raw = 8'h04;
        bus_write(ADDR_CTRL, ctrl_model.raw);
        bus_read_check(ADDR_STATUS, 8'h00, "idle status");
        pulse_activity();
        watch_busy(HOLD, 1'b1);
        watch_busy(1, 1'b0);
        // Second pulse inside the hold restarts it
        pulse_activity();
        watch_busy(1000, 1'b1);
        pulse_activity();
        watch_busy(HOLD, 1'b1);
        watch_busy(4, 1'b0);

        // PWM on with all lamps lit in user mode
        bus_write(ADDR_LED_LO, 8'hA5);
        ctrl_model.raw = 8'h3F;
        bus_write(ADDR_CTRL, ctrl_model.raw);
        count_duty(8'd0);
        count_duty(8'd64);
        count_duty(8'd200);
        count_duty(8'd255);

        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/led_ctrl_top.sv
// ==================================================
// LED controller top level
// Register file, activity stretcher and output
// stage wired together
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module led_ctrl_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    // CPU register port
    input  wire led_regs_pkg::led_bus_req_t  io,
    output logic [7:0]                       io_readdata,
    // From the disk controller
    input  wire logic                        disk_activity,
    // Front panel lamps
    output led_out_pkg::mister_leds_t        leds,
    // Software LED word after dimming
    output logic [15:0]                      led_register
);

    import led_regs_pkg::*;
    import led_out_pkg::*;

    logic [15:0]          led_word;
    ctrl_word_u           ctrl;
    logic [PWM_WIDTH-1:0] pwm_level;
    // Shared by status readback and the disk lamp
    logic                 activity_busy;

    led_regfile u_regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .io            (io),
        .io_readdata   (io_readdata),
        .activity_busy (activity_busy),
        .led_word      (led_word),
        .ctrl          (ctrl),
        .pwm_level     (pwm_level)
    );

    // Hold time taken from the package default
    activity_stretch #(
        .HOLD_CYCLES (ACTIVITY_HOLD)
    ) u_stretch (
        .clk           (clk),
        .rst_n         (rst_n),
        .disk_activity (disk_activity),
        .activity_busy (activity_busy)
    );

    led_output_stage u_output (
        .clk           (clk),
        .rst_n         (rst_n),
        .led_word      (led_word),
        .ctrl          (ctrl),
        .pwm_level     (pwm_level),
        .activity_busy (activity_busy),
        .leds          (leds),
        .led_register  (led_register)
    );

endmodule

`default_nettype wire

// File: hw/led_output_stage.sv
// ==================================================
// LED output stage
// Free-running PWM, disk state mux and brightness
// gating of lamp states and the software LED word
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module led_output_stage (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    // Register contents
    input  wire logic [15:0]                           led_word,
    input  wire led_regs_pkg::ctrl_word_u              ctrl,
    input  wire logic [led_out_pkg::PWM_WIDTH-1:0]     pwm_level,
    // Stretched disk activity for system mode
    input  wire logic                                  activity_busy,
    // Front panel and software LEDs
    output led_out_pkg::mister_leds_t                  leds,
    output logic [15:0]                                led_register
);

    import led_out_pkg::*;

    logic [PWM_WIDTH-1:0] pwm_cnt;
    // High while gated outputs may light
    logic                 lit;
    logic                 disk_state;

    // Wraps freely, starts at zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // Level of N gives N lit cycles per period
    // PWM off means full on
    assign lit = !ctrl.fields.pwm_en || (pwm_cnt < pwm_level);

    // User mode shows disk_on, system mode shows activity
    assign disk_state = ctrl.fields.disk_mode ? ctrl.fields.disk_on : activity_busy;

    // Mode bits pass ungated
    assign leds.user  = ctrl.fields.user_on & lit;
    assign leds.power = {ctrl.fields.power_mode, ctrl.fields.power_on & lit};
    assign leds.disk  = {ctrl.fields.disk_mode, disk_state & lit};

    // Every software LED bit dims with the same phase
    assign led_register = led_word & {16{lit}};

endmodule

`default_nettype wire

// File: hw/activity_stretch.sv
// ==================================================
// Disk activity stretcher
// Holds a busy level for HOLD_CYCLES edges after
// the last edge with activity seen
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module activity_stretch #(
    parameter logic [15:0] HOLD_CYCLES = led_out_pkg::ACTIVITY_HOLD
) (
    input  wire logic clk,
    input  wire logic rst_n,
    // Pulse or level from the disk controller
    input  wire logic disk_activity,
    output logic      activity_busy
);

    // Remaining hold time
    logic [15:0] hold_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt      <= 16'd0;
            activity_busy <= 1'b0;
        end else if (disk_activity) begin
            // New activity restarts the full hold
            hold_cnt      <= HOLD_CYCLES;
            activity_busy <= 1'b1;
        end else if (hold_cnt != 16'd0) begin
            hold_cnt <= hold_cnt - 16'd1;
            // Busy drops together with the last step
            if (hold_cnt == 16'd1) begin
                activity_busy <= 1'b0;
            end
        end else begin
            // Idle, also covers a zero hold time
            activity_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/led_regfile.sv
// ==================================================
// LED controller register file
// Write decode for LED word, control and PWM level,
// combinational readback including status byte
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module led_regfile (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // CPU port
    input  wire led_regs_pkg::led_bus_req_t io,
    output logic [7:0]                    io_readdata,
    // Stretched disk activity, status only
    input  wire logic                     activity_busy,
    // Register contents toward the output stage
    output logic [15:0]                   led_word,
    output led_regs_pkg::ctrl_word_u      ctrl,
    output logic [7:0]                    pwm_level
);

    import led_regs_pkg::*;

    // Status byte as read at ADDR_STATUS
    logic [7:0] status;

    // Busy in bit 1, raw user_on in bit 0
    assign status = {6'b0, activity_busy, ctrl.fields.user_on};

    // Writes land on every edge with the strobe high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_word  <= LED_WORD_RESET;
            ctrl.raw  <= CTRL_RESET;
            pwm_level <= PWM_LEVEL_RESET;
        end else if (io.write) begin
            case (io.addr)
                ADDR_LED_LO: begin
                    led_word[7:0] <= io.wdata;
                end
                ADDR_LED_HI: begin
                    led_word[15:8] <= io.wdata;
                end
                ADDR_CTRL: begin
                    // Whole byte, reserved bits included
                    ctrl.raw <= io.wdata;
                end
                ADDR_PWM: begin
                    pwm_level <= io.wdata;
                end
                default: begin
                    // Status and unmapped addresses ignore writes
                end
            endcase
        end
    end

    // Readback follows io.addr with no delay
    always_comb begin
        case (io.addr)
            ADDR_LED_LO: begin
                io_readdata = led_word[7:0];
            end
            ADDR_LED_HI: begin
                io_readdata = led_word[15:8];
            end
            ADDR_CTRL: begin
                io_readdata = ctrl.raw;
            end
            ADDR_PWM: begin
                io_readdata = pwm_level;
            end
            ADDR_STATUS: begin
                io_readdata = status;
            end
            default: begin
                // Unmapped reads as zero
                io_readdata = 8'h00;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/led_out_pkg.sv
// ==================================================
// Front-panel LED output definitions
// LED bundle struct, activity hold time, PWM width
// ==================================================

`default_nettype none

package led_out_pkg;

    // USER, POWER and DISK lamps
    // For power and disk, bit 1 is the mode and bit 0 the state
    typedef struct packed {
        logic       user;
        logic [1:0] power;
        logic [1:0] disk;
    } mister_leds_t;

    // Cycles the disk lamp stays lit after the last activity
    localparam logic [15:0] ACTIVITY_HOLD = 16'd5000;

    // Counter and level width of the brightness PWM
    localparam int PWM_WIDTH = 8;

endpackage

`default_nettype wire

// File: hw/led_regs_pkg.sv
// ==================================================
// LED controller register map and bus types
// Register addresses, CPU bus request struct,
// control byte fields and union, reset values
// ==================================================

`default_nettype none

package led_regs_pkg;

    // Register addresses on the byte-wide CPU port
    localparam logic [7:0] ADDR_LED_LO = 8'h00;
    localparam logic [7:0] ADDR_LED_HI = 8'h01;
    localparam logic [7:0] ADDR_CTRL   = 8'h02;
    localparam logic [7:0] ADDR_PWM    = 8'h03;
    localparam logic [7:0] ADDR_STATUS = 8'h04;

    // One CPU bus cycle, write strobe plus data
    typedef struct packed {
        logic [7:0] addr;
        logic       write;
        logic [7:0] wdata;
    } led_bus_req_t;

    // Control byte, user_on at bit 0
    typedef struct packed {
        logic [1:0] reserved;
        logic       pwm_en;
        // DISK state when disk_mode selects user mode
        logic       disk_on;
        // 1 = user mode, 0 = system mode
        logic       disk_mode;
        logic       power_on;
        logic       power_mode;
        logic       user_on;
    } ctrl_fields_t;

    // Same byte seen raw by the bus and as fields by the LED logic
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t fields;
    } ctrl_word_u;

    // Register values after reset
    localparam logic [15:0] LED_WORD_RESET  = 16'h0000;
    localparam logic [7:0]  CTRL_RESET      = 8'h00;
    localparam logic [7:0]  PWM_LEVEL_RESET = 8'hFF;

endpackage

`default_nettype wire
